/* rec_pkg.sv */
// shared widths and types for the input recorder
// the testbench pulls the same names for its golden checks
package rec_pkg;

    // basic widths
    localparam int REC_W = 8;
    localparam int JOY_W = 6;
    localparam int BTN_W = 4;
    localparam int CNT_W = 8;

    // one byte, used for samples, record bytes and memory words
    typedef logic [REC_W-1:0] rec_byte_t;

    // joystick directions and buttons, one player
    typedef logic [JOY_W-1:0] joy_t;

    // start or coin, one bit per player
    // only player one is recorded
    typedef logic [BTN_W-1:0] btn_t;

    // frames without a change, saturating
    typedef logic [CNT_W-1:0] frame_cnt_t;

    // count value that forces a record even with no change
    localparam frame_cnt_t FRAME_CNT_MAX = '1;

    // marker written during the clear phase
    // even addresses get MARK_EVEN, odd ones MARK_ODD
    localparam rec_byte_t MARK_EVEN = 8'hff;
    localparam rec_byte_t MARK_ODD  = 8'h00;

    // recorder FSM
    typedef enum logic [1:0] {
        CLEARING,
        IDLE,
        WR_COUNT,
        WR_DIFF
    } rec_state_t;

endpackage

/* frame_sampler.sv */
`timescale 1ns/100ps

// takes one input snapshot per video frame
// snapshot is taken on the falling edge of vertical sync
module frame_sampler #(
    parameter int ACTIVE_LOW = 1
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              vs,
    input  rec_pkg::btn_t     game_start,
    input  rec_pkg::btn_t     game_coin,
    input  rec_pkg::joy_t     joystick,
    output logic              sample_valid,
    output rec_pkg::rec_byte_t sample
);

    // 1 flips start/coin so that a pressed button reads high
    localparam logic POL = (ACTIVE_LOW != 0);

    // vs from the previous cycle
    logic vs_l;
    // high for one cycle when vs goes from high to low
    logic vs_fall;
    // sample byte built from the current inputs
    rec_pkg::rec_byte_t sample_nx;

    assign vs_fall = vs_l & ~vs;

    // joystick in the top six bits
    // player one start in bit 1, coin in bit 0
    // players two to four are not recorded
    assign sample_nx = {joystick, game_start[0] ^ POL, game_coin[0] ^ POL};

    // edge detector and strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vs_l         <= 1'b0;
            sample_valid <= 1'b0;
        end else begin
            vs_l         <= vs;
            // strobe follows the edge that first sees vs low
            sample_valid <= vs_fall;
        end
    end

    // sample byte
    // held until the next frame
    always_ff @(posedge clk) begin
        if (vs_fall) begin
            sample <= sample_nx;
        end
    end

    // recorder needs two cycles per record
    // so no strobe in the two cycles after one
    a_strobe_spacing : assert property (
        @(posedge clk) disable iff (rst)
        sample_valid |=> !sample_valid ##1 !sample_valid
    ) else $error("sample strobes less than three cycles apart");

endmodule

/* input_recorder.sv */
`timescale 1ns/100ps

// compressed input recorder
// fills the memory with a marker first, then writes
// a two byte record every time the inputs change:
//   byte 0  frames passed without a change
//   byte 1  old sample xor new sample
module input_recorder #(
    parameter int RECAW = 13
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               run,
    input  logic               sample_valid,
    input  rec_pkg::rec_byte_t sample,
    output logic               wr_en,
    output logic [RECAW-1:0]   wr_addr,
    output rec_pkg::rec_byte_t wr_data,
    output logic               cleared
);

    rec_pkg::rec_state_t state;

    // last sample that went into a record
    rec_pkg::rec_byte_t last;
    // changed bits of the pending record
    rec_pkg::rec_byte_t diff;
    // unchanged frames since the last record
    rec_pkg::frame_cnt_t cnt;

    // strobe that is taken into account
    logic take;
    // a record has to be written for this frame
    logic need_rec;

    // only while idle and enabled
    assign take = sample_valid && run && (state == rec_pkg::IDLE);

    // sample changed or counter saturated
    assign need_rec = (sample != last) || (cnt == rec_pkg::FRAME_CNT_MAX);

    // memory writes happen in every state but idle
    assign wr_en = (state != rec_pkg::IDLE);

    // write data mux
    always_comb begin
        case (state)
            rec_pkg::CLEARING: begin
                // marker ff on even and 00 on odd addresses
                wr_data = wr_addr[0] ? rec_pkg::MARK_ODD : rec_pkg::MARK_EVEN;
            end
            rec_pkg::WR_COUNT: begin
                wr_data = cnt;
            end
            rec_pkg::WR_DIFF: begin
                wr_data = diff;
            end
            default: begin
                // not written in idle
                wr_data = cnt;
            end
        endcase
    end

    // FSM, address and frame counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= rec_pkg::CLEARING;
            wr_addr <= '0;
            cleared <= 1'b0;
            cnt     <= '0;
            last    <= '0;
        end else begin
            case (state)
                rec_pkg::CLEARING: begin
                    // one address per cycle
                    // wraps back to zero after the last one
                    wr_addr <= wr_addr + 1'b1;
                    if (&wr_addr) begin
                        cleared <= 1'b1;
                        state   <= rec_pkg::IDLE;
                    end
                end
                rec_pkg::IDLE: begin
                    if (take) begin
                        if (need_rec) begin
                            last  <= sample;
                            state <= rec_pkg::WR_COUNT;
                        end else begin
                            cnt <= cnt + 1'b1;
                        end
                    end
                end
                rec_pkg::WR_COUNT: begin
                    wr_addr <= wr_addr + 1'b1;
                    state   <= rec_pkg::WR_DIFF;
                end
                rec_pkg::WR_DIFF: begin
                    // record done so counting starts again
                    wr_addr <= wr_addr + 1'b1;
                    cnt     <= '0;
                    state   <= rec_pkg::IDLE;
                end
                default: begin
                    state <= rec_pkg::IDLE;
                end
            endcase
        end
    end

    // xor of new and old sample
    // set bits mark the changed inputs
    always_ff @(posedge clk) begin
        if (take && need_rec) begin
            diff <= sample ^ last;
        end
    end

    // sampler has no back-pressure
    // a strobe must never land in the middle of a record
    a_no_strobe_in_record : assert property (
        @(posedge clk) disable iff (rst)
        sample_valid |-> (state != rec_pkg::WR_COUNT && state != rec_pkg::WR_DIFF)
    ) else $error("sample strobe while a record is being written");

endmodule

/* dual_port_ram.sv */
`timescale 1ns/100ps

// byte memory, one write port and one read port
// both on the same clock
// read is registered and returns old data on a collision
module dual_port_ram #(
    parameter int AW = 13
) (
    input  logic               clk,
    input  logic               we,
    input  logic [AW-1:0]      waddr,
    input  rec_pkg::rec_byte_t wdata,
    input  logic [AW-1:0]      raddr,
    output rec_pkg::rec_byte_t rdata
);

    // 2^AW bytes
    rec_pkg::rec_byte_t mem [0:(2**AW)-1];

    // write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // read port, one cycle of latency
    // same-address write lands after this read
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

    // an unknown address would corrupt an arbitrary byte
    a_waddr_known : assert property (
        @(posedge clk)
        we |-> !$isunknown(waddr)
    ) else $error("write with unknown address");

endmodule

/* rec_inputs_top.sv */
`timescale 1ns/100ps

// input recorder subsystem
// sampler -> recorder -> memory, host reads through rd_addr/rd_data
module rec_inputs_top #(
    // memory address width, 2^RECAW bytes of record
    parameter int RECAW      = 13,
    // 1 when start and coin are active low
    parameter int ACTIVE_LOW = 1
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               vs,
    input  logic               run,
    input  rec_pkg::btn_t      game_start,
    input  rec_pkg::btn_t      game_coin,
    input  rec_pkg::joy_t      joystick,
    input  logic [RECAW-1:0]   rd_addr,
    output rec_pkg::rec_byte_t rd_data,
    output logic               cleared
);

    // sampler to recorder
    logic               sample_valid;
    rec_pkg::rec_byte_t sample;

    // recorder to memory
    logic               wr_en;
    logic [RECAW-1:0]   wr_addr;
    rec_pkg::rec_byte_t wr_data;

    // one sample per frame
    frame_sampler #(
        .ACTIVE_LOW (ACTIVE_LOW)
    ) u_sampler (
        .clk          (clk),
        .rst          (rst),
        .vs           (vs),
        .game_start   (game_start),
        .game_coin    (game_coin),
        .joystick     (joystick),
        .sample_valid (sample_valid),
        .sample       (sample)
    );

    // clear phase and record writer
    input_recorder #(
        .RECAW (RECAW)
    ) u_recorder (
        .clk          (clk),
        .rst          (rst),
        .run          (run),
        .sample_valid (sample_valid),
        .sample       (sample),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .cleared      (cleared)
    );

    // record storage
    // read side is the host download port
    dual_port_ram #(
        .AW (RECAW)
    ) u_ram (
        .clk   (clk),
        .we    (wr_en),
        .waddr (wr_addr),
        .wdata (wr_data),
        .raddr (rd_addr),
        .rdata (rd_data)
    );

endmodule

/* tb_rec_inputs.sv */
`timescale 1ns/100ps

// testbench for the input recorder subsystem
// replays golden_inputs.txt one video frame at a time
// E lines read the memory back at that point of the replay
module tb_rec_inputs;

    localparam int RECAW = 8;
    localparam int DEPTH = 2 ** RECAW;

    logic               clk;
    logic               rst;
    logic               vs;
    logic               run;
    rec_pkg::btn_t      game_start;
    rec_pkg::btn_t      game_coin;
    rec_pkg::joy_t      joystick;
    logic [RECAW-1:0]   rd_addr;
    rec_pkg::rec_byte_t rd_data;
    logic               cleared;

    // wrong bytes read back
    int   value_errs;
    // timeouts, golden file trouble
    int   other_errs;
    // bytes compared
    int   checks;
    // set on a timeout, ends the replay early
    logic stop;

    rec_inputs_top #(
        .RECAW      (RECAW),
        .ACTIVE_LOW (1)
    ) dut (
        .clk        (clk),
        .rst        (rst),
        .vs         (vs),
        .run        (run),
        .game_start (game_start),
        .game_coin  (game_coin),
        .joystick   (joystick),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .cleared    (cleared)
    );

    // 4 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // length of one vs phase, 20 to 40 cycles
    function automatic int phase_len();
        return 20 + int'($urandom % 21);
    endfunction

    // one frame: vs high, then low
    // inputs settle long before the falling edge
    task automatic play_frame(input rec_pkg::btn_t st, input rec_pkg::btn_t co,
                              input rec_pkg::joy_t jy, input logic rn);
        int   n;
        int   gap;
        logic seen;
        @(posedge clk);
        game_start <= st;
        game_coin  <= co;
        joystick   <= jy;
        run        <= rn;
        vs         <= 1'b1;
        gap = phase_len();
        repeat (gap) @(posedge clk);
        vs <= 1'b0;
        // sampler strobe, one cycle after the edge that sees vs low
        seen = 1'b0;
        n = 0;
        while (!seen && n < 8) begin
            @(negedge clk);
            seen = dut.u_sampler.sample_valid;
            n++;
        end
        if (!seen) begin
            $display("timeout: no sample strobe after the vs falling edge at %0t", $time);
            other_errs++;
            stop = 1'b1;
        end
        // low phase, long enough for the record write
        gap = phase_len();
        repeat (gap) @(posedge clk);
    endtask

    // registered read, data one cycle after the address
    task automatic read_byte(input logic [RECAW-1:0] a, output rec_pkg::rec_byte_t d);
        @(posedge clk);
        rd_addr <= a;
        @(posedge clk);
        @(negedge clk);
        d = rd_data;
    endtask

    task automatic check_byte(input logic [RECAW-1:0] a, input rec_pkg::rec_byte_t exp);
        rec_pkg::rec_byte_t got;
        read_byte(a, got);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: address %02h expected %02h got %02h",
                     $time, a, exp, got);
            value_errs++;
        end
    endtask

    // clear phase takes one cycle per address
    task automatic wait_cleared();
        int n;
        n = 0;
        while (!cleared && n < 300) begin
            @(negedge clk);
            n++;
        end
        if (!cleared) begin
            $display("timeout: cleared did not rise within 300 cycles of reset");
            other_errs++;
            stop = 1'b1;
        end else if (n < 256) begin
            $display("cleared rose after %0d cycles, before every address was filled", n);
            other_errs++;
        end
    endtask

    // marker: ff on even addresses, 00 on odd ones
    task automatic check_clear_pattern();
        int a;
        for (a = 0; a < DEPTH; a++) begin
            check_byte(a[RECAW-1:0], (a % 2 == 0) ? 8'hff : 8'h00);
        end
    endtask

    // S lines drive frames, E lines compare a byte
    task automatic replay_golden();
        int          fd;
        int          code;
        int          hold;
        int          f;
        string       line;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic [31:0] f4;
        fd = $fopen("golden_inputs.txt", "r");
        if (fd == 0) begin
            $display("could not open golden_inputs.txt");
            other_errs++;
            return;
        end
        while (!stop && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() == 0) begin
                continue;
            end
            if (line[0] == "S") begin
                code = $sscanf(line, "S %d %h %h %h %h", hold, f1, f2, f3, f4);
                if (code != 5) begin
                    $display("malformed stimulus line in golden file: %s", line);
                    other_errs++;
                end else begin
                    for (f = 0; f < hold && !stop; f++) begin
                        play_frame(f1[3:0], f2[3:0], f3[5:0], f4[0]);
                    end
                end
            end else if (line[0] == "E") begin
                code = $sscanf(line, "E %h %h", f1, f2);
                if (code != 2) begin
                    $display("malformed expect line in golden file: %s", line);
                    other_errs++;
                end else begin
                    check_byte(f1[RECAW-1:0], f2[7:0]);
                end
            end
        end
        $fclose(fd);
    endtask

    initial begin
        void'($urandom(32'h4749_bd72));
        value_errs = 0;
        other_errs = 0;
        checks     = 0;
        stop       = 1'b0;
        rst        = 1'b1;
        vs         = 1'b0;
        run        = 1'b0;
        // buttons released, active low
        game_start = '1;
        game_coin  = '1;
        joystick   = '0;
        rd_addr    = '0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        wait_cleared();
        if (!stop) begin
            check_clear_pattern();
            replay_golden();
        end
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errs, other_errs);
        if (value_errs == 0 && other_errs == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* golden_inputs.txt */
# S frames(dec) start(hex) coin(hex) joystick(hex) run : inputs held for that many frames
# E address(hex) byte(hex) : expected memory byte at this point of the replay
# change records from address 0
S 3 f f 01 1
S 1 f f 03 1
S 2 f f 23 1
# start and coin pressed, active low, bits 1 and 0
S 4 e e 23 1
# players two to four are not recorded
S 2 0 0 23 1
S 1 f f 23 1
# run low, neither recorded nor counted
S 5 f f 3f 0
S 2 f f 23 1
S 1 f f 00 1
E 00 00
E 01 04
E 02 02
E 03 08
E 04 00
E 05 80
E 06 01
E 07 03
E 08 05
E 09 03
E 0a 02
E 0b 8c
# past the last record, still the clear marker
E 0c ff
E 0d 00
E 0e ff
E 0f 00
# 300 unchanged frames, one saturated record then 44 counted
S 300 f f 00 1
S 1 f f 10 1
E 0c ff
E 0d 00
E 0e 2c
E 0f 40
E 10 ff
E 11 00
# 116 saturated records fill 10 to f7, then 7 counted frames
S 29703 f f 10 1
S 1 f f 11 1
S 1 f f 13 1
S 2 f f 33 1
S 1 e f 33 1
# record address wraps, oldest bytes overwritten
S 3 f e 33 1
S 1 f f 00 1
S 1 f f 01 1
E f8 07
E f9 04
E fa 00
E fb 08
E fc 00
E fd 80
E fe 01
E ff 02
E 00 00
E 01 03
E 02 02
E 03 cd
E 04 00
E 05 04
# older records beyond the newest one
E 06 01
E 07 03
E 0e 2c
E 0f 40
E 10 ff
E 11 00
E 80 ff
E 81 00

/* tb.f */
rec_pkg.sv
frame_sampler.sv
input_recorder.sv
dual_port_ram.sv
rec_inputs_top.sv
tb_rec_inputs.sv

/* run.sh */
#!/bin/sh
# build and run the testbench with Verilator, result taken from sim.log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f tb.f --top-module tb_rec_inputs -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q ">>> FAIL" sim.log && { echo "simulation reported failure"; exit 1; }
grep -q ">>> PASS" sim.log || { echo "no result line in sim.log"; exit 1; }
echo "simulation passed"
exit 0
